/* verilog/join_defs.svh */
// word geometry for the stream joiner; only 8-byte little-endian words are supported.
`ifndef JOIN_DEFS_SVH
`define JOIN_DEFS_SVH

// ------------------------------
// word geometry
// ------------------------------

// bytes per data word.
`define JOIN_BYTES 8

// width of a byte count.
// must hold 0 through JOIN_BYTES inclusive.
// it must also hold a residue plus a full word, so 15 max.
`define JOIN_CNT_W 4

`endif

/* verilog/stream_pkg.sv */
// beat type shared by every stream port; keep must be a contiguous run of ones from byte 0.
`default_nettype none

`include "join_defs.svh"

package stream_pkg;

   // ------------------------------
   // stream beat
   // ------------------------------

   // one transfer on a valid/ready byte stream.
   // byte 0 sits in data[0] (little endian).
   typedef struct packed {
      logic [`JOIN_BYTES-1:0][7:0] data;
      logic [`JOIN_BYTES-1:0]      keep;
      logic                        last;
   } beat_t;

   // keep bit i qualifies data byte i.
   // last marks the final beat of a packet.

endpackage

`default_nettype wire

/* verilog/join_pkg.sv */
// control types for the joiner; the byte count is sized for a 7-byte residue plus one word.
`default_nettype none

`include "join_defs.svh"

package join_pkg;

   // ------------------------------
   // control state encodings
   // ------------------------------

   // which input the sequencer forwards.
   typedef enum logic {
      SRC_HEADER,
      SRC_PAYLOAD
   } src_t;

   // packer mode; FLUSH emits the spilled remainder as a last word.
   typedef enum logic {
      PACK,
      FLUSH
   } pack_state_t;

   // byte count for keep counts and the residue count.
   typedef logic [`JOIN_CNT_W-1:0] byte_cnt_t;

endpackage

`default_nettype wire

/* verilog/hdr_pyld_sequencer.sv */
// combinational source select; a header must end with last set before its payload is taken.
`timescale 1ns/1ps
`default_nettype none

module hdr_pyld_sequencer (
   input  logic              clk,
   input  logic              resetn,
   input  stream_pkg::beat_t hdr_beat,
   input  logic              hdr_valid,
   output logic              hdr_ready,
   input  stream_pkg::beat_t pyld_beat,
   input  logic              pyld_valid,
   output logic              pyld_ready,
   output stream_pkg::beat_t seq_beat,
   output logic              seq_valid,
   output logic              seq_hdr_end,
   input  logic              seq_ready
);

   join_pkg::src_t src;
   logic           on_hdr;
   logic           seq_xfer;

   assign on_hdr   = (src == join_pkg::SRC_HEADER);
   assign seq_xfer = seq_valid && seq_ready;

   // ------------------------------
   // source state
   // ------------------------------

   // header until its last beat goes, then payload until its last beat goes.
   always_ff @(posedge clk) begin
      if (!resetn) begin
         src <= join_pkg::SRC_HEADER;
      end else if (seq_xfer && on_hdr && hdr_beat.last) begin
         src <= join_pkg::SRC_PAYLOAD;
      end else if (seq_xfer && !on_hdr && pyld_beat.last) begin
         src <= join_pkg::SRC_HEADER;
      end
   end

   // ------------------------------
   // forward path
   // ------------------------------

   always_comb begin
      seq_beat = on_hdr ? hdr_beat : pyld_beat;
      // last on the link means end of the joined packet.
      if (on_hdr) begin
         seq_beat.last = 1'b0;
      end
      seq_valid   = on_hdr ? hdr_valid : pyld_valid;
      seq_hdr_end = on_hdr && hdr_valid && hdr_beat.last;
      // ready goes back to the selected input only.
      hdr_ready   = on_hdr && seq_ready;
      pyld_ready  = !on_hdr && seq_ready;
   end

   // payload stays held off until the header's last beat and after its own last beat.
   a_hdr_first: assert property (@(posedge clk) disable iff (!resetn)
      ((hdr_valid && hdr_ready && !hdr_beat.last)
       || (pyld_valid && pyld_ready && pyld_beat.last)) |=> !pyld_ready);

endmodule

`default_nettype wire

/* verilog/byte_packer.sv */
// packs a gap-free byte stream into full words; input keep must be a prefix, never empty.
`timescale 1ns/1ps
`default_nettype none

`include "join_defs.svh"

module byte_packer (
   input  logic              clk,
   input  logic              resetn,
   input  stream_pkg::beat_t seq_beat,
   input  logic              seq_valid,
   input  logic              seq_hdr_end,
   output logic              seq_ready,
   output stream_pkg::beat_t pk_beat,
   output logic              pk_valid,
   input  logic              pk_ready
);

   localparam int B = `JOIN_BYTES;

   join_pkg::pack_state_t state;
   logic [B-1:0][7:0]     res_data;
   join_pkg::byte_cnt_t   res_cnt;
   join_pkg::byte_cnt_t   in_cnt;
   join_pkg::byte_cnt_t   total;
   logic [2*B-1:0][7:0]   comb;
   logic                  out_free;
   logic                  in_xfer;
   logic                  keep_ok;

   // number of ones in a prefix keep.
   function automatic join_pkg::byte_cnt_t keep_cnt(input logic [B-1:0] keep);
      join_pkg::byte_cnt_t n;
      n = '0;
      for (int i = 0; i < B; i++) begin
         n = n + join_pkg::byte_cnt_t'(keep[i]);
      end
      return n;
   endfunction

   // prefix keep for a byte count of 0 to B.
   function automatic logic [B-1:0] cnt_keep(input join_pkg::byte_cnt_t cnt);
      logic [B-1:0] k;
      for (int i = 0; i < B; i++) begin
         k[i] = (i < int'(cnt));
      end
      return k;
   endfunction

   // ------------------------------
   // byte alignment
   // ------------------------------

   // the output register must be empty or draining to take anything.
   assign out_free  = !pk_valid || pk_ready;
   assign seq_ready = (state == join_pkg::PACK) && out_free;
   assign in_xfer   = seq_valid && seq_ready;
   assign in_cnt    = keep_cnt(seq_beat.keep);
   // the sum is at most 7 + 8 and fits the count type.
   assign total     = res_cnt + in_cnt;

   // residue first, then incoming bytes right above it; zeros past total.
   always_comb begin
      for (int i = 0; i < 2*B; i++) begin
         comb[i] = 8'h00;
         if (i < int'(res_cnt)) begin
            comb[i] = res_data[i];
         end else if (i < int'(total)) begin
            comb[i] = seq_beat.data[i - int'(res_cnt)];
         end
      end
   end

   // ------------------------------
   // residue and output word
   // ------------------------------

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state    <= join_pkg::PACK;
         res_cnt  <= '0;
         pk_valid <= 1'b0;
      end else begin
         // word leaves unless replaced below.
         if (pk_valid && pk_ready) begin
            pk_valid <= 1'b0;
         end
         if (state == join_pkg::FLUSH) begin
            // leftover bytes go out as the last word.
            if (out_free) begin
               pk_valid     <= 1'b1;
               pk_beat.data <= res_data;
               pk_beat.keep <= cnt_keep(res_cnt);
               pk_beat.last <= 1'b1;
               res_cnt      <= '0;
               state        <= join_pkg::PACK;
            end
         end else if (in_xfer) begin
            if (seq_beat.last && (total <= join_pkg::byte_cnt_t'(B))) begin
               // packet ends within this word.
               pk_valid     <= 1'b1;
               pk_beat.data <= comb[B-1:0];
               pk_beat.keep <= cnt_keep(total);
               pk_beat.last <= 1'b1;
               res_cnt      <= '0;
            end else if (total >= join_pkg::byte_cnt_t'(B)) begin
               // full word out and the overflow stays as residue.
               pk_valid     <= 1'b1;
               pk_beat.data <= comb[B-1:0];
               pk_beat.keep <= '1;
               pk_beat.last <= 1'b0;
               res_data     <= comb[2*B-1:B];
               res_cnt      <= total - join_pkg::byte_cnt_t'(B);
               // spill on the last beat needs a second word.
               if (seq_beat.last) begin
                  state <= join_pkg::FLUSH;
               end
            end else begin
               // not enough for a word yet.
               res_data <= comb[B-1:0];
               res_cnt  <= total;
            end
         end
      end
   end

   // ------------------------------
   // checks
   // ------------------------------

   // prefix, non-empty, and short only at the header end or packet end.
   assign keep_ok = ((seq_beat.keep & (seq_beat.keep + 1'b1)) == '0)
                    && (seq_beat.keep != '0)
                    && ((&seq_beat.keep) || seq_hdr_end || seq_beat.last);

   a_keep_prefix: assert property (@(posedge clk) disable iff (!resetn)
      seq_valid |-> keep_ok);

   a_hold_stable: assert property (@(posedge clk) disable iff (!resetn)
      pk_valid && !pk_ready |=> pk_valid && $stable(pk_beat));

   a_full_words: assert property (@(posedge clk) disable iff (!resetn)
      pk_valid && !pk_beat.last |-> &pk_beat.keep);

endmodule

`default_nettype wire

/* verilog/skid_buffer.sv */
// two-entry output register; ready toward the packer comes straight from a flop.
`timescale 1ns/1ps
`default_nettype none

module skid_buffer (
   input  logic              clk,
   input  logic              resetn,
   input  stream_pkg::beat_t pk_beat,
   input  logic              pk_valid,
   output logic              pk_ready,
   output stream_pkg::beat_t out_beat,
   output logic              out_valid,
   input  logic              out_ready
);

   stream_pkg::beat_t spill_beat;
   logic              spill_valid;
   logic              in_xfer;
   logic              main_free;

   // free entry exists as long as the spill slot is empty.
   assign pk_ready  = !spill_valid;
   assign in_xfer   = pk_valid && pk_ready;
   assign main_free = !out_valid || out_ready;

   // ------------------------------
   // entry occupancy
   // ------------------------------

   always_ff @(posedge clk) begin
      if (!resetn) begin
         out_valid   <= 1'b0;
         spill_valid <= 1'b0;
      end else if (main_free) begin
         out_valid   <= spill_valid || in_xfer;
         spill_valid <= 1'b0;
      end else if (in_xfer) begin
         // out_ready fell while a beat was accepted.
         spill_valid <= 1'b1;
      end
   end

   // spill drains first, so order is kept.
   always_ff @(posedge clk) begin
      if (main_free) begin
         if (spill_valid) begin
            out_beat <= spill_beat;
         end else if (in_xfer) begin
            out_beat <= pk_beat;
         end
      end else if (in_xfer) begin
         spill_beat <= pk_beat;
      end
   end

   // a full buffer that cannot drain keeps both beats untouched.
   a_no_overflow: assert property (@(posedge clk) disable iff (!resetn)
      out_valid && spill_valid && !out_ready |=> out_valid && spill_valid
      && $stable(out_beat) && $stable(spill_beat));

endmodule

`default_nettype wire

/* verilog/stream_join.sv */
// header/payload joiner top; single clock, little endian, payload follows header with no gap.
`timescale 1ns/1ps
`default_nettype none

module stream_join (
   input  logic              clk,
   input  logic              resetn,
   input  stream_pkg::beat_t hdr_beat,
   input  logic              hdr_valid,
   output logic              hdr_ready,
   input  stream_pkg::beat_t pyld_beat,
   input  logic              pyld_valid,
   output logic              pyld_ready,
   output stream_pkg::beat_t out_beat,
   output logic              out_valid,
   input  logic              out_ready
);

   // ------------------------------
   // internal links
   // ------------------------------

   stream_pkg::beat_t seq_beat;
   logic              seq_valid;
   logic              seq_ready;
   logic              seq_hdr_end;
   stream_pkg::beat_t pk_beat;
   logic              pk_valid;
   logic              pk_ready;

   // header then payload, one stream.
   hdr_pyld_sequencer u_seq (
      .clk         (clk),
      .resetn      (resetn),
      .hdr_beat    (hdr_beat),
      .hdr_valid   (hdr_valid),
      .hdr_ready   (hdr_ready),
      .pyld_beat   (pyld_beat),
      .pyld_valid  (pyld_valid),
      .pyld_ready  (pyld_ready),
      .seq_beat    (seq_beat),
      .seq_valid   (seq_valid),
      .seq_hdr_end (seq_hdr_end),
      .seq_ready   (seq_ready)
   );

   // shift across the boundary into full words.
   byte_packer u_pack (
      .clk         (clk),
      .resetn      (resetn),
      .seq_beat    (seq_beat),
      .seq_valid   (seq_valid),
      .seq_hdr_end (seq_hdr_end),
      .seq_ready   (seq_ready),
      .pk_beat     (pk_beat),
      .pk_valid    (pk_valid),
      .pk_ready    (pk_ready)
   );

   // registered output stage.
   skid_buffer u_skid (
      .clk       (clk),
      .resetn    (resetn),
      .pk_beat   (pk_beat),
      .pk_valid  (pk_valid),
      .pk_ready  (pk_ready),
      .out_beat  (out_beat),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

endmodule

`default_nettype wire

/* bench/join_checker.sv */
// checks each output transfer against the next expected word; bytes outside keep are not compared.
`timescale 1ns/1ps
`default_nettype none

`include "join_defs.svh"

module join_checker (
   input logic              clk,
   input logic              resetn,
   input stream_pkg::beat_t out_beat,
   input logic              out_valid,
   input logic              out_ready
);

   stream_pkg::beat_t exp_q [$];
   stream_pkg::beat_t exp_w;
   stream_pkg::beat_t got_w;
   int                err_cnt    = 0;
   int                test_err   = 0;
   int                test_cnt   = 0;
   int                word_cnt   = 0;
   int                word_total = 0;

   task automatic push_word(input stream_pkg::beat_t w);
      exp_q.push_back(w);
   endtask

   function automatic int pending();
      return exp_q.size();
   endfunction

   // one line per finished test.
   task automatic end_test(input string name);
      test_cnt++;
      $display("test %0d %s: %0d words, %0d errors", test_cnt, name, word_cnt, test_err);
      word_cnt = 0;
      test_err = 0;
   endtask

   task automatic report_mismatch(input string field, input logic [63:0] e, input logic [63:0] g);
      $display("[FAIL] %0t ns: word %0d %s expected %h got %h", $time, word_cnt, field, e, g);
      err_cnt++;
      test_err++;
   endtask

   // ------------------------------
   // compare on every output transfer
   // ------------------------------

   always @(posedge clk) begin
      if (resetn && out_valid && out_ready) begin
         if (exp_q.size() == 0) begin
            $display("unexpected output word at %0t ns, no word was expected", $time);
            err_cnt++;
            test_err++;
         end else begin
            exp_w = exp_q.pop_front();
            got_w = out_beat;
            // only bytes inside keep carry data.
            for (int i = 0; i < `JOIN_BYTES; i++) begin
               if (!exp_w.keep[i]) begin
                  got_w.data[i] = 8'h00;
               end
            end
            if (got_w.keep != exp_w.keep) begin
               report_mismatch("keep", 64'(exp_w.keep), 64'(got_w.keep));
            end
            if (got_w.last != exp_w.last) begin
               report_mismatch("last", 64'(exp_w.last), 64'(got_w.last));
            end
            if (got_w.data != exp_w.data) begin
               report_mismatch("data", 64'(exp_w.data), 64'(got_w.data));
            end
         end
         word_cnt++;
         word_total++;
      end
   end

endmodule

`default_nettype wire

/* bench/tb_stream_join.sv */
// 16-bit Fibonacci LFSR stimulus from seed 47; packets hold at most 24 header and 40 payload bytes.
`timescale 1ns/1ps
`default_nettype none

`include "join_defs.svh"

module tb_stream_join;

   localparam int W         = `JOIN_BYTES;
   localparam int N_PKTS    = 56;
   // 3 header beats plus 5 payload beats at most.
   localparam int PKT_BEATS = 8;
   localparam int TIMEOUT   = 4 * N_PKTS * PKT_BEATS + 200;

   logic              clk = 1'b0;
   logic              resetn;
   stream_pkg::beat_t hdr_beat;
   stream_pkg::beat_t pyld_beat;
   stream_pkg::beat_t out_beat;
   logic              hdr_valid;
   logic              hdr_ready;
   logic              pyld_valid;
   logic              pyld_ready;
   logic              out_valid;
   logic              out_ready;

   // index 0 is the header stream, 1 the payload stream.
   stream_pkg::beat_t in_beat [2];
   logic              in_valid [2];
   logic              in_ready [2];
   stream_pkg::beat_t beats [2][PKT_BEATS];
   int                gaps [2][PKT_BEATS];
   logic [7:0]        pkt [0:63];
   int                pkt_len;
   logic [15:0]       lfsr;
   logic [15:0]       stall_lfsr;
   logic              stall_bit;
   logic              stall_en;
   logic              gap_en;
   int                cycles = 0;

   assign hdr_beat    = in_beat[0];
   assign hdr_valid   = in_valid[0];
   assign pyld_beat   = in_beat[1];
   assign pyld_valid  = in_valid[1];
   assign in_ready[0] = hdr_ready;
   assign in_ready[1] = pyld_ready;

   always #20 clk = ~clk;

   stream_join DUT (
      .clk        (clk),
      .resetn     (resetn),
      .hdr_beat   (hdr_beat),
      .hdr_valid  (hdr_valid),
      .hdr_ready  (hdr_ready),
      .pyld_beat  (pyld_beat),
      .pyld_valid (pyld_valid),
      .pyld_ready (pyld_ready),
      .out_beat   (out_beat),
      .out_valid  (out_valid),
      .out_ready  (out_ready)
   );

   join_checker chk (
      .clk       (clk),
      .resetn    (resetn),
      .out_beat  (out_beat),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   // ------------------------------
   // stimulus helpers
   // ------------------------------

   // taps 16, 14, 13, 11.
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic int take_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = (v << 1) | int'(lfsr[0]);
      end
      return v;
   endfunction

   // cnt packet bytes from off with a prefix keep.
   function automatic stream_pkg::beat_t pack_bytes(input int off, input int cnt, input logic last);
      stream_pkg::beat_t bt;
      bt = '0;
      for (int i = 0; i < cnt; i++) begin
         bt.data[i] = pkt[off + i];
         bt.keep[i] = 1'b1;
      end
      bt.last = last;
      return bt;
   endfunction

   // header and payload bytes back to back, cut into W-byte words.
   function automatic stream_pkg::beat_t expected_word(input int w);
      int rem;
      rem = pkt_len - W * w;
      return pack_bytes(W * w, (rem > W) ? W : rem, rem <= W);
   endfunction

   // ready only moves on rising edges, so it is settled at the falling edge.
   task automatic drive(input int s, input int n);
      for (int b = 0; b < n; b++) begin
         if (gaps[s][b] > 0) begin
            in_valid[s] = 1'b0;
            repeat (gaps[s][b]) @(negedge clk);
         end
         in_valid[s] = 1'b1;
         in_beat[s]  = beats[s][b];
         while (!in_ready[s]) @(negedge clk);
         @(negedge clk);
      end
      in_valid[s] = 1'b0;
   endtask

   task automatic send_packet(input int hlen, input int plen);
      int n [2];
      int len [2];
      int base;
      int rem;
      pkt_len = hlen + plen;
      for (int i = 0; i < pkt_len; i++) begin
         pkt[i] = 8'(take_bits(8));
      end
      for (int w = 0; w < (pkt_len + W - 1) / W; w++) begin
         chk.push_word(expected_word(w));
      end
      len[0] = hlen;
      len[1] = plen;
      for (int s = 0; s < 2; s++) begin
         base = (s == 0) ? 0 : hlen;
         n[s] = (len[s] + W - 1) / W;
         for (int b = 0; b < n[s]; b++) begin
            rem = len[s] - W * b;
            beats[s][b] = pack_bytes(base + W * b, (rem > W) ? W : rem, b == n[s] - 1);
            gaps[s][b]  = 0;
            if (gap_en && take_bits(2) == 0) begin
               gaps[s][b] = 1 + take_bits(1);
            end
         end
      end
      fork
         drive(0, n[0]);
         drive(1, n[1]);
      join
   endtask

   task automatic send_random();
      int hlen;
      int plen;
      hlen = 1 + take_bits(5) % 24;
      plen = 1 + take_bits(6) % 40;
      send_packet(hlen, plen);
   endtask

   task automatic finish_test(input string name);
      while (chk.pending() > 0) @(negedge clk);
      repeat (2) @(negedge clk);
      chk.end_test(name);
   endtask

   // ------------------------------
   // output stalls and run limit
   // ------------------------------

   // out_ready low on about one cycle in four.
   always @(negedge clk) begin
      stall_lfsr = lfsr_step(stall_lfsr);
      stall_bit  = stall_lfsr[0];
      stall_lfsr = lfsr_step(stall_lfsr);
      out_ready  = !(stall_en && stall_bit && stall_lfsr[0]);
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > TIMEOUT) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
         $display("*** FAILED ***");
         $finish;
      end
   end

   initial begin
      resetn      = 1'b0;
      in_valid[0] = 1'b0;
      in_valid[1] = 1'b0;
      in_beat[0]  = '0;
      in_beat[1]  = '0;
      out_ready   = 1'b1;
      stall_en    = 1'b0;
      gap_en      = 1'b0;
      lfsr        = 16'd47;
      stall_lfsr  = 16'd47;
      repeat (10) @(negedge clk);
      resetn = 1'b1;
      send_packet(8, 16);
      send_packet(16, 8);
      finish_test("aligned join");
      send_packet(5, 11);
      send_packet(3, 21);
      finish_test("shifted join");
      // residue plus the last payload beat spill past one word.
      send_packet(5, 12);
      send_packet(7, 15);
      finish_test("flush word");
      send_packet(7, 9);
      send_packet(13, 3);
      send_packet(1, 1);
      send_packet(24, 40);
      finish_test("back-to-back packets");
      gap_en   = 1'b1;
      stall_en = 1'b1;
      repeat (6) send_random();
      finish_test("back-pressure");
      repeat (40) send_random();
      finish_test("randomized mix");
      $display("tests %0d, words %0d, errors %0d", chk.test_cnt, chk.word_total, chk.err_cnt);
      if (chk.err_cnt == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
+incdir+verilog
verilog/stream_pkg.sv
verilog/join_pkg.sv
verilog/hdr_pyld_sequencer.sv
verilog/byte_packer.sv
verilog/skid_buffer.sv
verilog/stream_join.sv
bench/join_checker.sv
bench/tb_stream_join.sv

/* Makefile */
BIN := obj_dir/Vtb_stream_join

.PHONY: run clean

$(BIN): flist.f $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_stream_join -f flist.f

run: $(BIN)
	$(BIN) | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
